// ==== rtl/scsiPkg.sv ====
/*
 * Shared types for the SCSI transfer sequencer of the DMA controller.
 * Holds the sequencer state encoding and the DMA direction encoding.
 * Modules take these by a wildcard import in the body or by scoped
 * names in their port lists.
 */
`default_nettype none

package scsiPkg;

    localparam int SEQ_STATE_W = 3;                 // Bits needed for six states

    // Sequencer states, CPU path then DMA path
    typedef enum logic [SEQ_STATE_W-1:0] {
        IDLE       = 3'd0,                          // Waiting for a CPU or DMA request
        CPU_ACCESS = 3'd1,                          // Chip select plus RE or WE
        CPU_TERM   = 3'd2,                          // Fire the cycle termination
        CPU_WAIT   = 3'd3,                          // Hold until CPU request drops
        DMA_XFER   = 3'd4,                          // One DACK byte transfer
        DMA_WAIT   = 3'd5                           // Hold until DREQ goes away
    } seqState_e;

    // DMA direction as seen from the FIFO
    typedef enum logic {
        DIR_F2S = 1'b0,                             // FIFO to SCSI chip
        DIR_S2F = 1'b1                              // SCSI chip to FIFO
    } xferDir_e;

endpackage : scsiPkg

`default_nettype wire

// ==== rtl/scsiSequencer.sv ====
/*
 * Transfer sequencer for the WD33C93-style SCSI chip.
 * Samples the CPU and DMA requests, picks which transfer runs and steps
 * it through its states. All strobe outputs are plain state decodes and
 * must be registered by the parent before they reach the chip.
 */
`timescale 1ns/1ps
`default_nettype none

module scsiSequencer (
    input  wire               BBCLK,                // System clock
    input  wire               CRESET_,              // Async reset, active low
    input  wire               cpuReq_i,             // CPU wants a SCSI register access
    input  wire               rw_i,                 // 1 means read
    input  wire               dreqN_i,              // DMA request from chip, active low
    input  scsiPkg::xferDir_e dmaDir_i,             // DMA direction
    input  wire               boEq3_i,              // Current byte is byte 3
    input  wire               fifoFull_i,           // FIFO full level
    input  wire               fifoEmpty_i,          // FIFO empty level
    input  wire               riFifoPend_i,         // Longword write to FIFO pending
    input  wire               rdFifoPend_i,         // Longword read from FIFO pending
    output logic              cpu2S_o,              // CPU to SCSI datapath enable
    output logic              s2Cpu_o,              // SCSI to CPU datapath enable
    output logic              s2F_o,                // SCSI to FIFO datapath enable
    output logic              f2S_o,                // FIFO to SCSI datapath enable
    output logic              scsiCs_o,             // Chip select decode
    output logic              re_o,                 // Read strobe decode
    output logic              we_o,                 // Write strobe decode
    output logic              dack_o,               // DMA acknowledge decode
    output logic              incBo_o,              // Step FIFO byte pointer
    output logic              incNi_o,              // Step FIFO next-in pointer
    output logic              incNo_o,              // Step FIFO next-out pointer
    output logic              setRiFifo_o,          // Request longword write to FIFO
    output logic              setRdFifo_o,          // Request longword read from FIFO
    output logic              setDsack_o            // Start CPU cycle termination
);

    import scsiPkg::*;

    seqState_e state;                               // Current state
    seqState_e nextState;                           // Next state decode
    logic      cCpuReq;                             // Sampled CPU request
    logic      cDreqN;                              // Sampled DMA request, active low
    logic      fifoRoom;                            // FIFO can take or give a byte
    logic      dmaGo;                               // All DMA start conditions met

    // Single sampling stage for the asynchronous requests
    always_ff @(posedge BBCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cCpuReq <= 1'b0;
            cDreqN  <= 1'b1;                        // No DMA request after reset
        end else begin
            cCpuReq <= cpuReq_i;
            cDreqN  <= dreqN_i;
        end
    end

    // Direction picks which FIFO level blocks the byte
    assign fifoRoom = (dmaDir_i == DIR_S2F) ? !fifoFull_i : !fifoEmpty_i;

    // Pending longword requests hold off any new byte
    assign dmaGo = !cDreqN && !riFifoPend_i && !rdFifoPend_i && fifoRoom;

    always_ff @(posedge BBCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (cCpuReq) begin
                    nextState = CPU_ACCESS;         // CPU wins over DMA
                end else if (dmaGo) begin
                    nextState = DMA_XFER;
                end
            end
            CPU_ACCESS: nextState = CPU_TERM;
            CPU_TERM:   nextState = CPU_WAIT;
            CPU_WAIT: begin
                if (!cCpuReq) begin
                    nextState = IDLE;               // One access per request
                end
            end
            DMA_XFER:   nextState = DMA_WAIT;
            DMA_WAIT: begin
                if (cDreqN) begin
                    nextState = IDLE;               // One byte per DREQ assertion
                end
            end
            default:    nextState = IDLE;
        endcase
    end

    // Strobe and pulse decodes of the current state
    always_comb begin
        cpu2S_o     = 1'b0;
        s2Cpu_o     = 1'b0;
        s2F_o       = 1'b0;
        f2S_o       = 1'b0;
        scsiCs_o    = 1'b0;
        re_o        = 1'b0;
        we_o        = 1'b0;
        dack_o      = 1'b0;
        incBo_o     = 1'b0;
        incNi_o     = 1'b0;
        incNo_o     = 1'b0;
        setRiFifo_o = 1'b0;
        setRdFifo_o = 1'b0;
        setDsack_o  = 1'b0;
        case (state)
            CPU_ACCESS: begin
                scsiCs_o = 1'b1;
                re_o     = rw_i;                    // Register read
                s2Cpu_o  = rw_i;
                we_o     = !rw_i;                   // Register write
                cpu2S_o  = !rw_i;
            end
            CPU_TERM: begin
                setDsack_o = 1'b1;                  // Terminate after the strobe
            end
            DMA_XFER: begin
                dack_o  = 1'b1;
                incBo_o = 1'b1;
                if (dmaDir_i == DIR_S2F) begin
                    s2F_o       = 1'b1;
                    re_o        = 1'b1;
                    incNi_o     = boEq3_i;          // Longword complete, push it
                    setRiFifo_o = boEq3_i;
                end else begin
                    f2S_o       = 1'b1;
                    we_o        = 1'b1;
                    incNo_o     = boEq3_i;          // Longword drained, fetch next
                    setRdFifo_o = boEq3_i;
                end
            end
            default: begin
            end
        endcase
    end

endmodule : scsiSequencer

`default_nettype wire

// ==== rtl/scsiRequestLatch.sv ====
/*
 * Request and termination flags for the SCSI sequencer.
 * Holds the FIFO longword requests until the host side confirms them,
 * and the CPU cycle termination until the CPU strobe ends.
 */
`timescale 1ns/1ps
`default_nettype none

module scsiRequestLatch (
    input  wire  BBCLK,                             // System clock
    input  wire  CRESET_,                           // Async reset, active low
    input  wire  setRiFifo_i,                       // Set write-to-FIFO request
    input  wire  setRdFifo_i,                       // Set read-from-FIFO request
    input  wire  incFifo_i,                         // Longword written, clears riFifo
    input  wire  decFifo_i,                         // Longword read, clears rdFifo
    input  wire  setDsack_i,                        // Start cycle termination
    input  wire  cpuStrobe_i,                       // High while CPU cycle lasts
    output logic riFifo_o,                          // Write longword to FIFO pending
    output logic rdFifo_o,                          // Read longword from FIFO pending
    output logic dsackN_o                           // Cycle termination, active low
);

    logic dsackFlag;                                // Termination in progress

    // Confirm pulse beats a set pulse in the same cycle
    always_ff @(posedge BBCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            riFifo_o <= 1'b0;
        end else if (incFifo_i) begin
            riFifo_o <= 1'b0;
        end else if (setRiFifo_i) begin
            riFifo_o <= 1'b1;
        end
    end

    always_ff @(posedge BBCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            rdFifo_o <= 1'b0;
        end else if (decFifo_i) begin
            rdFifo_o <= 1'b0;
        end else if (setRdFifo_i) begin
            rdFifo_o <= 1'b1;
        end
    end

    // Released on the first edge that sees the strobe low
    always_ff @(posedge BBCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            dsackFlag <= 1'b0;
        end else if (!cpuStrobe_i) begin
            dsackFlag <= 1'b0;
        end else if (setDsack_i) begin
            dsackFlag <= 1'b1;
        end
    end

    assign dsackN_o = !dsackFlag;                   // Idle high

endmodule : scsiRequestLatch

`default_nettype wire

// ==== rtl/scsiBusController.sv ====
/*
 * Top level of the SCSI transfer sequencer.
 * Connects the sequencer to the request latch and registers the strobe
 * decodes so the chip and FIFO datapath see clean, glitch-free levels.
 */
`timescale 1ns/1ps
`default_nettype none

module scsiBusController (
    input  wire               BBCLK,                // System clock
    input  wire               CRESET_,              // Async reset, active low
    input  wire               cpuReq_i,             // CPU register access request
    input  wire               rw_i,                 // 1 means read
    input  wire               cpuStrobe_i,          // High while CPU cycle lasts
    input  wire               dreqN_i,              // DMA request, active low
    input  scsiPkg::xferDir_e dmaDir_i,             // DMA direction
    input  wire               boEq3_i,              // Current byte is byte 3
    input  wire               fifoFull_i,           // FIFO full level
    input  wire               fifoEmpty_i,          // FIFO empty level
    input  wire               incFifo_i,            // Longword written into FIFO
    input  wire               decFifo_i,            // Longword read out of FIFO
    output logic              cpu2S_o,              // CPU to SCSI datapath enable
    output logic              s2Cpu_o,              // SCSI to CPU datapath enable
    output logic              s2F_o,                // SCSI to FIFO datapath enable
    output logic              f2S_o,                // FIFO to SCSI datapath enable
    output logic              scsiCs_o,             // Chip select
    output logic              re_o,                 // Read strobe to chip
    output logic              we_o,                 // Write strobe to chip
    output logic              dack_o,               // DMA acknowledge to chip
    output logic              incBo_o,              // Step FIFO byte pointer
    output logic              incNi_o,              // Step FIFO next-in pointer
    output logic              incNo_o,              // Step FIFO next-out pointer
    output logic              riFifo_o,             // Write longword to FIFO pending
    output logic              rdFifo_o,             // Read longword from FIFO pending
    output logic              dsackN_o,             // CPU cycle termination, active low
    output logic              lByteN_o              // Load byte into FIFO, active low
);

    logic cpu2S;                                    // Unregistered decodes from sequencer
    logic s2Cpu;
    logic s2F;
    logic f2S;
    logic scsiCs;
    logic re;
    logic we;
    logic dack;
    logic incBo;
    logic incNi;
    logic incNo;
    logic setRiFifo;                                // One-cycle pulses into the latch
    logic setRdFifo;
    logic setDsack;

    scsiSequencer uSequencer (
        .BBCLK        (BBCLK),
        .CRESET_      (CRESET_),
        .cpuReq_i     (cpuReq_i),
        .rw_i         (rw_i),
        .dreqN_i      (dreqN_i),
        .dmaDir_i     (dmaDir_i),
        .boEq3_i      (boEq3_i),
        .fifoFull_i   (fifoFull_i),
        .fifoEmpty_i  (fifoEmpty_i),
        .riFifoPend_i (riFifo_o),                   // Pending flags hold off DMA
        .rdFifoPend_i (rdFifo_o),
        .cpu2S_o      (cpu2S),
        .s2Cpu_o      (s2Cpu),
        .s2F_o        (s2F),
        .f2S_o        (f2S),
        .scsiCs_o     (scsiCs),
        .re_o         (re),
        .we_o         (we),
        .dack_o       (dack),
        .incBo_o      (incBo),
        .incNi_o      (incNi),
        .incNo_o      (incNo),
        .setRiFifo_o  (setRiFifo),
        .setRdFifo_o  (setRdFifo),
        .setDsack_o   (setDsack)
    );

    scsiRequestLatch uRequestLatch (
        .BBCLK       (BBCLK),
        .CRESET_     (CRESET_),
        .setRiFifo_i (setRiFifo),
        .setRdFifo_i (setRdFifo),
        .incFifo_i   (incFifo_i),
        .decFifo_i   (decFifo_i),
        .setDsack_i  (setDsack),
        .cpuStrobe_i (cpuStrobe_i),
        .riFifo_o    (riFifo_o),
        .rdFifo_o    (rdFifo_o),
        .dsackN_o    (dsackN_o)
    );

    // One cycle behind the state, so strobes never glitch
    always_ff @(posedge BBCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cpu2S_o  <= 1'b0;
            s2Cpu_o  <= 1'b0;
            s2F_o    <= 1'b0;
            f2S_o    <= 1'b0;
            scsiCs_o <= 1'b0;
            re_o     <= 1'b0;
            we_o     <= 1'b0;
            dack_o   <= 1'b0;
            incBo_o  <= 1'b0;
            incNi_o  <= 1'b0;
            incNo_o  <= 1'b0;
        end else begin
            cpu2S_o  <= cpu2S;
            s2Cpu_o  <= s2Cpu;
            s2F_o    <= s2F;
            f2S_o    <= f2S;
            scsiCs_o <= scsiCs;
            re_o     <= re;
            we_o     <= we;
            dack_o   <= dack;
            incBo_o  <= incBo;
            incNi_o  <= incNi;
            incNo_o  <= incNo;
        end
    end

    assign lByteN_o = !(dack_o && re_o);            // Only on SCSI to FIFO bytes

endmodule : scsiBusController

`default_nettype wire

// ==== testbench/scsiBusController_properties.sv ====
/*
 * Concurrent assertions for the SCSI bus controller, bound into the top level.
 * Covers strobe exclusivity, FIFO request holding and the byte load level.
 */
`timescale 1ns/1ps
`default_nettype none

module scsiBusController_properties (
    input wire                            BBCLK,
    input wire                            CRESET_,
    input wire                            scsiCs_o,
    input wire                            dack_o,
    input wire                            re_o,
    input wire                            we_o,
    input wire                            riFifo_o,
    input wire                            rdFifo_o,
    input wire                            incFifo_i,
    input wire                            decFifo_i,
    input wire                            lByteN_o,
    input wire [scsiPkg::SEQ_STATE_W-1:0] seqState_i     // Sequencer state
);

    import scsiPkg::*;

    csDackExclusive: assert property (@(posedge BBCLK) disable iff (!CRESET_)
        !(scsiCs_o && dack_o)) else $error("Chip select and DACK high together");

    dackOneStrobe: assert property (@(posedge BBCLK) disable iff (!CRESET_)
        dack_o |-> (re_o ^ we_o)) else $error("DACK without exactly one of RE and WE");

    // DACK shows one edge after DMA_XFER, so the state has moved on to DMA_WAIT
    dackInWait: assert property (@(posedge BBCLK) disable iff (!CRESET_)
        dack_o |-> (seqState_i == DMA_WAIT)) else $error("DACK outside a DMA transfer");

    riFifoHold: assert property (@(posedge BBCLK) disable iff (!CRESET_)
        (riFifo_o && !incFifo_i) |=> riFifo_o) else $error("riFifo dropped before confirm");

    rdFifoHold: assert property (@(posedge BBCLK) disable iff (!CRESET_)
        (rdFifo_o && !decFifo_i) |=> rdFifo_o) else $error("rdFifo dropped before confirm");

    lByteLevel: assert property (@(posedge BBCLK)
        lByteN_o == !(dack_o && re_o)) else $error("lByteN does not follow DACK and RE");

endmodule : scsiBusController_properties

bind scsiBusController scsiBusController_properties uProps (
    .BBCLK      (BBCLK),
    .CRESET_    (CRESET_),
    .scsiCs_o   (scsiCs_o),
    .dack_o     (dack_o),
    .re_o       (re_o),
    .we_o       (we_o),
    .riFifo_o   (riFifo_o),
    .rdFifo_o   (rdFifo_o),
    .incFifo_i  (incFifo_i),
    .decFifo_i  (decFifo_i),
    .lByteN_o   (lByteN_o),
    .seqState_i (uSequencer.state)
);

`default_nettype wire

// ==== testbench/scsiBusControllerTb.sv ====
/*
 * Testbench for the SCSI bus controller.
 * Runs CPU register accesses, DMA bytes in both directions, FIFO blocking,
 * CPU priority and a random mix, comparing every strobe pulse with a
 * reference model of the transfer rules. Stops at the first mismatch.
 */
`timescale 1ns/1ps
`default_nettype none

module scsiBusControllerTb;

    import scsiPkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RANDOM_OPS = 200;
    localparam int NUM_OPS    = RANDOM_OPS + 30;        // Directed ops plus random mix
    localparam int OP_BOUND   = 40;                     // Cycles allowed per operation

    logic     BBCLK;
    logic     CRESET_;
    logic     cpuReq_i;
    logic     rw_i;
    logic     cpuStrobe_i;
    logic     dreqN_i;
    xferDir_e dmaDir_i;
    logic     boEq3_i;
    logic     fifoFull_i;
    logic     fifoEmpty_i;
    logic     incFifo_i;
    logic     decFifo_i;
    logic     cpu2S_o;
    logic     s2Cpu_o;
    logic     s2F_o;
    logic     f2S_o;
    logic     scsiCs_o;
    logic     re_o;
    logic     we_o;
    logic     dack_o;
    logic     incBo_o;
    logic     incNi_o;
    logic     incNo_o;
    logic     riFifo_o;
    logic     rdFifo_o;
    logic     dsackN_o;
    logic     lByteN_o;

    logic [11:0] actVec;                                // Observed strobes
    logic [11:0] expVec;                                // Expected strobes of current op
    logic [31:0] rngState;
    string       testName;
    int          dackCount = 0;                         // DACK pulses seen
    int          csCount   = 0;                         // Chip select pulses seen
    int          dreqCount = 0;                         // DREQ assertions driven
    logic        prevHigh  = 1'b0;                      // Pulse seen in previous cycle

    scsiBusController DUT (.*);

    assign actVec = {cpu2S_o, s2Cpu_o, s2F_o, f2S_o, scsiCs_o, re_o, we_o, dack_o,
                     incBo_o, incNi_o, incNo_o, lByteN_o};

    always #(CLK_PERIOD / 2) BBCLK = !BBCLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Bit order matches actVec and lByteN idles high
    function automatic logic [11:0] expStrobes(input logic isDma, input logic rd,
                                               input xferDir_e dir, input logic bo3);
        logic [11:0] v;
        v = 12'h001;
        if (!isDma) begin
            v[7]  = 1'b1;                               // Chip select
            v[6]  = rd;                                 // RE and S2CPU on a read
            v[10] = rd;
            v[5]  = !rd;                                // WE and CPU2S on a write
            v[11] = !rd;
        end else begin
            v[4] = 1'b1;                                // DACK
            v[3] = 1'b1;                                // Byte pointer step
            if (dir == DIR_S2F) begin
                v[9] = 1'b1;
                v[6] = 1'b1;
                v[2] = bo3;                             // Next-in on byte 3
                v[0] = 1'b0;                            // Byte loads into FIFO
            end else begin
                v[8] = 1'b1;
                v[5] = 1'b1;
                v[1] = bo3;                             // Next-out on byte 3
            end
        end
        return v;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] expVal,
                         input logic [31:0] actVal);
        if (expVal !== actVal) begin
            failRun($sformatf("FAIL %s/%s: expected 0x%0h, actual 0x%0h", testName, name,
                              expVal, actVal));
        end
    endtask

    task automatic expectIdle(input string name);
        check(name, 32'h001, 32'(actVec));              // All strobes low
        check(name, 32'h001, 32'({riFifo_o, rdFifo_o, dsackN_o}));
    endtask

    task automatic cpuAccess(input logic rd);
        int csBefore;
        @(posedge BBCLK);
        #1;
        csBefore    = csCount;
        rw_i        = rd;
        expVec      = expStrobes(1'b0, rd, dmaDir_i, 1'b0);
        cpuReq_i    = 1'b1;
        cpuStrobe_i = 1'b1;
        wait (scsiCs_o === 1'b1);
        #1;
        check("dsackEarly", 1, 32'(dsackN_o));          // Still high during the strobe
        @(posedge BBCLK);
        #1;
        check("csFall", 0, 32'(scsiCs_o));
        check("dsackFall", 0, 32'(dsackN_o));           // Falls with chip select
        cpuStrobe_i = 1'b0;                             // Cycle ends, request still up
        @(posedge BBCLK);
        #1;
        check("dsackRise", 1, 32'(dsackN_o));
        repeat (2) @(posedge BBCLK);
        #1;
        cpuReq_i = 1'b0;
        repeat (4) @(posedge BBCLK);
        check("oneAccess", csBefore + 1, csCount);
    endtask

    // One DREQ assertion that waits out a FIFO block or a pending longword
    task automatic dmaByte(input xferDir_e dir, input logic bo3, input logic blocked);
        int dackBefore;
        @(posedge BBCLK);
        #1;
        dmaDir_i    = dir;
        boEq3_i     = bo3;
        expVec      = expStrobes(1'b1, 1'b0, dir, bo3);
        fifoFull_i  = blocked && (dir == DIR_S2F);
        fifoEmpty_i = blocked && (dir == DIR_F2S);
        dreqN_i     = 1'b0;
        dreqCount++;
        if (blocked || riFifo_o || rdFifo_o) begin
            dackBefore = dackCount;
            repeat (6) @(posedge BBCLK);
            #1;
            check("holdOff", dackBefore, dackCount);
            incFifo_i = riFifo_o;                       // Host side takes the longword
            decFifo_i = rdFifo_o;
            @(posedge BBCLK);
            #1;
            incFifo_i = 1'b0;
            decFifo_i = 1'b0;
            check("confirm", 0, 32'({riFifo_o, rdFifo_o}));
            if (blocked) begin
                repeat (6) @(posedge BBCLK);            // FIFO level alone holds the byte
                #1;
                check("fifoBlock", dackBefore, dackCount);
                fifoFull_i  = 1'b0;
                fifoEmpty_i = 1'b0;
            end
        end
        wait (dack_o === 1'b1);
        @(posedge BBCLK);
        #1;
        dreqN_i = 1'b1;                                 // Chip drops DREQ on DACK
        repeat (2) @(posedge BBCLK);
        #1;
        check("fifoReq", 32'({bo3 && dir == DIR_S2F, bo3 && dir == DIR_F2S}),
              32'({riFifo_o, rdFifo_o}));
    endtask

    task automatic cpuBeatsDma();
        int dackBefore;
        @(posedge BBCLK);
        #1;
        dackBefore  = dackCount;
        rw_i        = 1'b1;
        dmaDir_i    = DIR_S2F;
        boEq3_i     = 1'b0;
        expVec      = expStrobes(1'b0, 1'b1, DIR_S2F, 1'b0);
        cpuReq_i    = 1'b1;
        cpuStrobe_i = 1'b1;
        dreqN_i     = 1'b0;                             // Same cycle as the CPU request
        dreqCount++;
        wait (scsiCs_o === 1'b1);
        check("priority", dackBefore, dackCount);
        @(posedge BBCLK);
        #1;
        expVec      = expStrobes(1'b1, 1'b0, DIR_S2F, 1'b0);
        cpuStrobe_i = 1'b0;
        cpuReq_i    = 1'b0;
        wait (dack_o === 1'b1);
        @(posedge BBCLK);
        #1;
        dreqN_i = 1'b1;
        repeat (2) @(posedge BBCLK);
    endtask

    // Compares every strobe pulse and checks that it lasts one cycle
    always @(negedge BBCLK) begin
        if (CRESET_ && (scsiCs_o || dack_o)) begin
            check("strobes", 32'(expVec), 32'(actVec));
            check("pulseWidth", 0, 32'(prevHigh));
            prevHigh = 1'b1;
            if (dack_o)
                dackCount++;
            if (scsiCs_o)
                csCount++;
        end else begin
            prevHigh = 1'b0;
        end
    end

    initial begin
        #(NUM_OPS * OP_BOUND * CLK_PERIOD);
        failRun("Watchdog timeout, the DUT stopped answering requests");
    end

    initial begin
        BBCLK       = 1'b0;
        CRESET_     = 1'b0;
        cpuReq_i    = 1'b0;
        rw_i        = 1'b0;
        cpuStrobe_i = 1'b0;
        dreqN_i     = 1'b1;
        dmaDir_i    = DIR_S2F;
        boEq3_i     = 1'b0;
        fifoFull_i  = 1'b0;
        fifoEmpty_i = 1'b0;
        incFifo_i   = 1'b0;
        decFifo_i   = 1'b0;
        expVec      = 12'h001;
        rngState    = 32'd59196;
        testName    = "reset";
        repeat (5) @(posedge BBCLK);
        #1;
        expectIdle("duringReset");
        repeat (5) @(posedge BBCLK);
        #1;
        CRESET_ = 1'b1;
        repeat (2) @(posedge BBCLK);
        #1;
        expectIdle("afterReset");
        testName = "cpuRead";
        cpuAccess(1'b1);
        testName = "cpuWrite";
        cpuAccess(1'b0);
        testName = "dmaS2F";
        for (int i = 0; i < 8; i++)
            dmaByte(DIR_S2F, (i % 4 == 3), 1'b0);
        testName = "dmaF2S";
        for (int i = 0; i < 8; i++)
            dmaByte(DIR_F2S, (i % 4 == 3), 1'b0);
        testName = "blockFull";
        dmaByte(DIR_S2F, 1'b0, 1'b1);
        testName = "blockEmpty";
        dmaByte(DIR_F2S, 1'b0, 1'b1);
        testName = "priority";
        cpuBeatsDma();
        testName = "random";
        for (int k = 0; k < RANDOM_OPS; k++) begin
            rngState = xorshift32(rngState);
            case (rngState[1:0])
                2'd0:    cpuAccess(1'b1);
                2'd1:    cpuAccess(1'b0);
                2'd2:    dmaByte(DIR_S2F, rngState[2], rngState[5:3] == 3'd0);
                default: dmaByte(DIR_F2S, rngState[2], rngState[5:3] == 3'd0);
            endcase
        end
        check("dreqCount", dreqCount, dackCount);       // One byte per DREQ
        $display("Result: PASSED");
        $finish;
    end

endmodule : scsiBusControllerTb

`default_nettype wire

// ==== sim.f ====
rtl/scsiPkg.sv
rtl/scsiSequencer.sv
rtl/scsiRequestLatch.sv
rtl/scsiBusController.sv
testbench/scsiBusController_properties.sv
testbench/scsiBusControllerTb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := scsiBusControllerTb
FILELIST  := sim.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'Result: PASSED' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
